//--- otter_mem.f
otter_mem_pkg.sv
bram.sv
sram.sv
mmio_regs.sv
load_align.sv
otter_mem.sv
otter_mem_props.sv
tb_otter_mem.sv

//--- run.sh
#!/usr/bin/env bash
# Build the otter_mem testbench with Verilator and run it
# Exit status follows the simulation, nonzero on $fatal or a failed assertion
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_otter_mem \
    -f otter_mem.f \
    -o sim_otter_mem

./obj_dir/sim_otter_mem

//--- tb_otter_mem.sv
module tb_otter_mem;

    timeunit 1ns;
    timeprecision 1ps;

    import otter_mem_pkg::*;

    localparam logic [31:0] MMIO_WINDOW = 32'h1100_0000;
    localparam int          N_WORDS     = 24;
    localparam int          N_LANE      = 16;
    localparam int          COUNT_GAP   = 7;
    // Upper bound on requests at one cycle each
    localparam int          N_STEPS     = 2 * N_WORDS + 6 * N_LANE + 64;
    localparam int          WATCHDOG_NS = N_STEPS * 40 + 8 * 20 + 500;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    mem_rsp_t    rsp;
    logic [31:0] gpio;

    // Reference model state
    logic [7:0]  shadow [logic [31:0]];
    logic [31:0] words [$];
    logic [31:0] exp_gpio;
    logic [31:0] exp_scratch;
    logic [31:0] live_cycles;
    logic [31:0] lfsr_state;

    // Read whose data shows up in the next cycle
    logic        pend_rd;
    logic [31:0] pend_data;

    otter_mem u_otter_mem (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .rsp  (rsp),
        .gpio (gpio)
    );

    always #10 clk = ~clk;

    // Cycles since reset release
    always @(posedge clk) begin
        if (rst)
            live_cycles <= 32'h0;
        else
            live_cycles <= live_cycles + 32'd1;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    // One LFSR step per bit with the result right aligned
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_req_t make_req(input logic [31:0] a, input size_e sz,
                                          input logic lu, input logic rd, input logic wr,
                                          input logic [31:0] d);
        mem_req_t r;
        r.addr  = a;
        r.size  = sz;
        r.lu    = lu;
        r.rd    = rd;
        r.wr    = wr;
        r.wdata = d;
        return r;
    endfunction

    // Little endian bytes taken from the low end of the store data
    function automatic void store_shadow(input logic [31:0] a, input size_e sz,
                                         input logic [31:0] d);
        int n;
        case (sz)
            BYTE:    n = 1;
            HALF:    n = 2;
            default: n = 4;
        endcase
        for (int i = 0; i < n; i++)
            shadow[a + i] = d[8*i +: 8];
    endfunction

    // Load result as RISC-V defines it for lb, lbu, lh, lhu, lw
    function automatic logic [31:0] load_value(input logic [31:0] a, input size_e sz,
                                               input logic lu);
        logic [31:0] v;
        case (sz)
            BYTE: begin
                v = {24'h0, shadow[a]};
                if (!lu && v[7])
                    v = v | 32'hFFFF_FF00;
            end
            HALF: begin
                v = {16'h0, shadow[a + 32'd1], shadow[a]};
                if (!lu && v[15])
                    v = v | 32'hFFFF_0000;
            end
            default: v = {shadow[a + 32'd3], shadow[a + 32'd2], shadow[a + 32'd1], shadow[a]};
        endcase
        return v;
    endfunction

    // One request cycle with checks sampled at the falling edge
    task automatic step(input mem_req_t r, input logic exp_err, input logic [31:0] exp_data,
                        input logic count_rd);
        logic [31:0] want;
        #1;
        req  = r;
        want = count_rd ? live_cycles : exp_data;
        @(negedge clk);
        if (r.rd || r.wr) begin
            assert (rsp.error === exp_err)
            else abort_run($sformatf("error at %0t: error flag %b, expected %b",
                                     $time, rsp.error, exp_err));
        end
        assert (gpio === exp_gpio)
        else abort_run($sformatf("error at %0t: gpio %h, expected %h", $time, gpio, exp_gpio));
        // Data of the read issued one cycle earlier
        if (pend_rd) begin
            assert (rsp.rdata === pend_data)
            else abort_run($sformatf("error at %0t: rdata %h, expected %h",
                                     $time, rsp.rdata, pend_data));
        end
        pend_rd   = r.rd;
        pend_data = want;
        @(posedge clk);
    endtask

    task automatic idle();
        step('0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic mem_access(input logic [31:0] a, input size_e sz, input logic lu,
                              input logic wr, input logic [31:0] d, input logic bad);
        logic [31:0] exp;
        exp = 32'h0;
        if (!wr && !bad)
            exp = load_value(a, sz, lu);
        step(make_req(a, sz, lu, !wr, wr, d), bad, exp, 1'b0);
        if (wr && !bad)
            store_shadow(a, sz, d);
    endtask

    task automatic mmio_access(input logic [7:0] ofs, input size_e sz, input logic wr,
                               input logic [31:0] d, input logic bad);
        logic [31:0] exp;
        exp = 32'h0;
        if (!wr && !bad && ofs == MMIO_GPIO_OFS)
            exp = exp_gpio;
        if (!wr && !bad && ofs == MMIO_SCRATCH_OFS)
            exp = exp_scratch;
        step(make_req(MMIO_WINDOW + {24'h0, ofs}, sz, 1'b0, !wr, wr, d), bad, exp,
             !wr && !bad && (ofs == MMIO_COUNT_OFS));
        if (wr && !bad && ofs == MMIO_GPIO_OFS)
            exp_gpio = d;
        if (wr && !bad && ofs == MMIO_SCRATCH_OFS)
            exp_scratch = d;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] a;
        logic [31:0] o;
        clk         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        exp_gpio    = 32'h0;
        exp_scratch = 32'h0;
        pend_rd     = 1'b0;
        pend_data   = 32'h0;
        lfsr_state  = 32'h1b0e73de;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);

        // Word stores spread over the whole array and then loads back to back
        for (int i = 0; i < N_WORDS; i++) begin
            a = take_bits(13) << 2;
            words.push_back(a);
            mem_access(a, WORD, 1'b0, 1'b1, take_bits(32), 1'b0);
        end
        foreach (words[i])
            mem_access(words[i], WORD, 1'b0, 1'b0, 32'h0, 1'b0);

        // Sub-word stores touch only their lanes and loads extend both ways
        for (int i = 0; i < N_LANE; i++) begin
            a = words[take_bits(8) % N_WORDS];
            o = take_bits(2);
            mem_access(a + o, BYTE, 1'b0, 1'b1, take_bits(32), 1'b0);
            mem_access(a, WORD, 1'b0, 1'b0, 32'h0, 1'b0);
            mem_access(a + o, BYTE, i[0], 1'b0, 32'h0, 1'b0);
            o = take_bits(1) << 1;
            mem_access(a + o, HALF, 1'b0, 1'b1, take_bits(32), 1'b0);
            mem_access(a, WORD, 1'b0, 1'b0, 32'h0, 1'b0);
            mem_access(a + o, HALF, ~i[0], 1'b0, 32'h0, 1'b0);
        end

        // Rejected stores leave memory alone
        a = words[0];
        mem_access(a + 32'd1, HALF, 1'b0, 1'b1, take_bits(32), 1'b1);
        mem_access(a + 32'd3, HALF, 1'b0, 1'b1, take_bits(32), 1'b1);
        mem_access(a + 32'd2, WORD, 1'b0, 1'b1, take_bits(32), 1'b1);
        mem_access(a, size_e'(2'b11), 1'b0, 1'b1, take_bits(32), 1'b1);
        // Aliases word a if the range check were missing
        mem_access(a | 32'h0000_8000, WORD, 1'b0, 1'b1, take_bits(32), 1'b1);
        mem_access(32'h2000_0040, WORD, 1'b0, 1'b1, take_bits(32), 1'b1);
        mem_access(a, WORD, 1'b0, 1'b0, 32'h0, 1'b0);

        // Rejected loads return zero between good ones
        mem_access(a + 32'd1, HALF, 1'b1, 1'b0, 32'h0, 1'b1);
        mem_access(a + 32'd3, WORD, 1'b0, 1'b0, 32'h0, 1'b1);
        mem_access(a, WORD, 1'b0, 1'b0, 32'h0, 1'b0);
        mem_access(a, size_e'(2'b11), 1'b0, 1'b0, 32'h0, 1'b1);
        mem_access(a | 32'h0000_8000, WORD, 1'b0, 1'b0, 32'h0, 1'b1);
        mem_access(32'h1100_0100, WORD, 1'b0, 1'b0, 32'h0, 1'b1);
        mem_access(words[1], WORD, 1'b0, 1'b0, 32'h0, 1'b0);

        // MMIO registers
        mmio_access(MMIO_GPIO_OFS, WORD, 1'b1, take_bits(32), 1'b0);
        mmio_access(MMIO_GPIO_OFS, WORD, 1'b0, 32'h0, 1'b0);
        mmio_access(MMIO_SCRATCH_OFS, WORD, 1'b1, take_bits(32), 1'b0);
        mmio_access(MMIO_SCRATCH_OFS, WORD, 1'b0, 32'h0, 1'b0);
        mem_access(words[2], WORD, 1'b0, 1'b0, 32'h0, 1'b0);
        mmio_access(MMIO_GPIO_OFS, BYTE, 1'b1, take_bits(32), 1'b1);
        mmio_access(MMIO_GPIO_OFS, HALF, 1'b0, 32'h0, 1'b1);
        mmio_access(8'h0C, WORD, 1'b1, take_bits(32), 1'b1);
        mmio_access(8'h0C, WORD, 1'b0, 32'h0, 1'b1);
        // Accepted but has no effect on the count
        mmio_access(MMIO_COUNT_OFS, WORD, 1'b1, 32'hFFFF_0000, 1'b0);
        mmio_access(MMIO_SCRATCH_OFS, HALF, 1'b0, 32'h0, 1'b1);
        mmio_access(MMIO_GPIO_OFS, WORD, 1'b0, 32'h0, 1'b0);
        mmio_access(MMIO_SCRATCH_OFS, WORD, 1'b0, 32'h0, 1'b0);

        // Two counter reads COUNT_GAP cycles apart
        // Each one compared with the cycles since reset release
        mmio_access(MMIO_COUNT_OFS, WORD, 1'b0, 32'h0, 1'b0);
        repeat (COUNT_GAP - 1) idle();
        mmio_access(MMIO_COUNT_OFS, WORD, 1'b0, 32'h0, 1'b0);
        idle();

        idle();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- otter_mem_props.sv
module otter_mem_props #(
    parameter logic [31:0] MMIO_BASE = 32'h1100_0000
) (
    input logic                    clk,
    input logic                    rst,
    input otter_mem_pkg::mem_req_t req,
    input otter_mem_pkg::mem_rsp_t rsp,
    input logic [31:0]             gpio
);

    timeunit 1ns;
    timeprecision 1ps;

    import otter_mem_pkg::*;

    localparam logic [31:0] GPIO_ADDR = MMIO_BASE + {24'h0, MMIO_GPIO_OFS};

    logic gpio_wr;
    logic gpio_written;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Word store to the GPIO register that the block accepts
    assign gpio_wr = req.wr && !req.rd && (req.size == WORD)
                  && (req.addr == GPIO_ADDR) && !rsp.error;

    // Set once the first GPIO write has been sampled
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_written <= 1'b0;
        end else if (gpio_wr) begin
            gpio_written <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////////////////////

    // One strobe at a time
    no_rd_and_wr: assert property (@(posedge clk) disable iff (rst)
        !(req.rd && req.wr))
        else $error("read and write strobes are high in the same cycle");

    // Output stays at its reset value until software writes it
    gpio_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !gpio_written |-> (gpio == 32'h0))
        else $error("gpio moved away from zero before any GPIO write");

    // Failed loads hand back zero
    error_read_zero: assert property (@(posedge clk) disable iff (rst)
        (req.rd && rsp.error) |=> (rsp.rdata == 32'h0))
        else $error("read data is not zero after a read with error");

    // Only an accepted GPIO write moves the pins, one edge later
    gpio_moves_on_write: assert property (@(posedge clk) disable iff (rst)
        !$stable(gpio) |-> $past(gpio_wr))
        else $error("gpio changed without a GPIO write in the cycle before");

endmodule

bind otter_mem otter_mem_props #(
    .MMIO_BASE (MMIO_BASE)
) u_otter_mem_props (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .rsp  (rsp),
    .gpio (gpio)
);

//--- otter_mem.sv
module otter_mem #(
    parameter int          SRAM_ADDR_WIDTH = 15,
    parameter logic [31:0] MMIO_BASE       = 32'h1100_0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  otter_mem_pkg::mem_req_t req,
    output otter_mem_pkg::mem_rsp_t rsp,
    output logic [31:0]             gpio
);

    import otter_mem_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Target answers into the aligner
    ////////////////////////////////////////////////////////////////////////////

    tgt_rsp_t sram_rsp;
    tgt_rsp_t mmio_rsp;

    // Data memory at address zero
    sram #(
        .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
    ) u_sram (
        .clk (clk),
        .req (req),
        .tgt (sram_rsp)
    );

    // Peripheral window
    mmio_regs #(
        .MMIO_BASE (MMIO_BASE)
    ) u_mmio_regs (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .tgt  (mmio_rsp),
        .gpio (gpio)
    );

    // Error merge and load data shaping
    load_align u_load_align (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .sram_rsp (sram_rsp),
        .mmio_rsp (mmio_rsp),
        .rsp      (rsp)
    );

endmodule

//--- load_align.sv
module load_align (
    input  logic                    clk,
    input  logic                    rst,
    input  otter_mem_pkg::mem_req_t req,
    input  otter_mem_pkg::tgt_rsp_t sram_rsp,
    input  otter_mem_pkg::tgt_rsp_t mmio_rsp,
    output otter_mem_pkg::mem_rsp_t rsp
);

    import otter_mem_pkg::*;

    // Which target owns the word in flight
    localparam logic [1:0] SEL_NONE = 2'd0;
    localparam logic [1:0] SEL_SRAM = 2'd1;
    localparam logic [1:0] SEL_MMIO = 2'd2;

    logic        unmapped;
    logic        err;
    logic [1:0]  sel_q;
    logic [1:0]  ofs_q;
    size_e       size_q;
    logic        lu_q;
    logic [31:0] word;
    logic [31:0] shifted;

    ////////////////////////////////////////////////////////////////////////////
    // Error merge in the same cycle as the strobe
    ////////////////////////////////////////////////////////////////////////////

    assign unmapped = ~sram_rsp.hit & ~mmio_rsp.hit;
    assign err = (req.rd | req.wr) & (unmapped | sram_rsp.error | mmio_rsp.error);

    assign rsp.error = err;

    // A failed read selects no target and so returns zero
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= SEL_NONE;
        end else if (req.rd) begin
            if (err)
                sel_q <= SEL_NONE;
            else if (sram_rsp.hit)
                sel_q <= SEL_SRAM;
            else
                sel_q <= SEL_MMIO;
        end
    end

    // Lane info for the word coming back
    always_ff @(posedge clk) begin
        if (rst) begin
            ofs_q  <= 2'b00;
            size_q <= WORD;
            lu_q   <= 1'b0;
        end else if (req.rd) begin
            ofs_q  <= req.addr[1:0];
            size_q <= req.size;
            lu_q   <= req.lu;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Lane shift and extension
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (sel_q)
            SEL_SRAM: word = sram_rsp.rdata;
            SEL_MMIO: word = mmio_rsp.rdata;
            default:  word = 32'h0;
        endcase
    end

    assign shifted = word >> {ofs_q, 3'b000};

    always_comb begin
        case (size_q)
            BYTE:    rsp.rdata = {{24{~lu_q & shifted[7]}}, shifted[7:0]};
            HALF:    rsp.rdata = {{16{~lu_q & shifted[15]}}, shifted[15:0]};
            default: rsp.rdata = shifted;
        endcase
    end

endmodule

//--- mmio_regs.sv
module mmio_regs #(
    parameter logic [31:0] MMIO_BASE = 32'h1100_0000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  otter_mem_pkg::mem_req_t req,
    output otter_mem_pkg::tgt_rsp_t tgt,
    output logic [31:0]             gpio
);

    import otter_mem_pkg::*;

    // Upper 24 bits select the 256 byte window
    localparam logic [23:0] BASE_PAGE = MMIO_BASE[31:8];

    logic        hit;
    logic [7:0]  ofs;
    logic        ofs_ok;
    logic        bad;
    logic        good_wr;
    logic        good_rd;
    logic [31:0] gpio_q;
    logic [31:0] scratch_q;
    logic [31:0] count_q;
    logic [31:0] rd_word;
    logic [31:0] rdata_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign hit = (req.addr[31:8] == BASE_PAGE);
    assign ofs = req.addr[7:0];

    // Three registers mapped, everything else in the window is a hole
    assign ofs_ok = (ofs == MMIO_GPIO_OFS)
                 || (ofs == MMIO_SCRATCH_OFS)
                 || (ofs == MMIO_COUNT_OFS);

    // Word access only
    assign bad = (req.size != WORD) || !ofs_ok;

    assign good_wr = hit & req.wr & ~bad;
    assign good_rd = hit & req.rd & ~bad;

    assign tgt.hit   = hit;
    assign tgt.error = hit & bad;

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    // Read mux, counter value as seen before this edge
    always_comb begin
        case (ofs)
            MMIO_GPIO_OFS:    rd_word = gpio_q;
            MMIO_SCRATCH_OFS: rd_word = scratch_q;
            MMIO_COUNT_OFS:   rd_word = count_q;
            default:          rd_word = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_q    <= 32'h0;
            scratch_q <= 32'h0;
            count_q   <= 32'h0;
            rdata_q   <= 32'h0;
        end else begin
            // Free running, writes to it are dropped
            count_q <= count_q + 32'd1;
            if (good_wr && ofs == MMIO_GPIO_OFS) begin
                gpio_q <= req.wdata;
            end
            if (good_wr && ofs == MMIO_SCRATCH_OFS) begin
                scratch_q <= req.wdata;
            end
            // Read word held until the next good read
            if (good_rd) begin
                rdata_q <= rd_word;
            end
        end
    end

    assign tgt.rdata = rdata_q;
    assign gpio      = gpio_q;

endmodule

//--- sram.sv
module sram #(
    parameter int SRAM_ADDR_WIDTH = 15
) (
    input  logic                   clk,
    input  otter_mem_pkg::mem_req_t req,
    output otter_mem_pkg::tgt_rsp_t tgt
);

    import otter_mem_pkg::*;

    // Four bytes per word
    localparam int RAM_ADDR_WIDTH = SRAM_ADDR_WIDTH - 2;

    logic                      hit;
    logic                      misalign;
    logic [1:0]                ofs;
    logic [3:0]                lane_we;
    logic [3:0]                ram_we;
    logic [31:0]               lane_data;
    logic [RAM_ADDR_WIDTH-1:0] word_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Region and alignment checks
    ////////////////////////////////////////////////////////////////////////////

    // Region starts at zero, so all upper bits must be clear
    assign hit = (req.addr[31:SRAM_ADDR_WIDTH] == '0);
    assign ofs = req.addr[1:0];

    always_comb begin
        case (req.size)
            BYTE:    misalign = 1'b0;
            HALF:    misalign = ofs[0];
            WORD:    misalign = (ofs != 2'b00);
            // Size code 11
            default: misalign = 1'b1;
        endcase
    end

    // Only report errors for our own region
    assign tgt.hit   = hit;
    assign tgt.error = hit & misalign;

    ////////////////////////////////////////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////////////////////////////////////////

    // Lane pattern before gating
    always_comb begin
        case (req.size)
            BYTE:    lane_we = 4'b0001 << ofs;
            HALF:    lane_we = 4'b0011 << ofs;
            WORD:    lane_we = 4'b1111;
            default: lane_we = 4'b0000;
        endcase
    end

    // Bad writes never reach the array
    assign ram_we = (hit && req.wr && !misalign) ? lane_we : 4'b0000;

    // Store data moved up onto the addressed lanes
    assign lane_data = req.wdata << {ofs, 3'b000};
    assign word_addr = req.addr[SRAM_ADDR_WIDTH-1:2];

    bram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .RAM_BUS_WIDTH  (32)
    ) u_bram (
        .clk  (clk),
        .rd   (req.rd & hit),
        .we   (ram_we),
        .addr (word_addr),
        .data (lane_data),
        .out  (tgt.rdata)
    );

endmodule

//--- bram.sv
module bram #(
    parameter int RAM_ADDR_WIDTH = 13,
    parameter int RAM_BUS_WIDTH  = 32
) (
    input  logic                       clk,
    input  logic                       rd,
    input  logic [RAM_BUS_WIDTH/8-1:0] we,
    input  logic [RAM_ADDR_WIDTH-1:0]  addr,
    input  logic [RAM_BUS_WIDTH-1:0]   data,
    output logic [RAM_BUS_WIDTH-1:0]   out
);

    localparam int NUM_LANES = RAM_BUS_WIDTH / 8;
    localparam int DEPTH     = 2 ** RAM_ADDR_WIDTH;

    // Storage array, one word per entry
    logic [RAM_BUS_WIDTH-1:0] mem [DEPTH];

    // Byte lane writes
    // Each enable covers eight bits of the word
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (we[i]) begin
                mem[addr][i*8 +: 8] <= data[i*8 +: 8];
            end
        end
    end

    // Registered read
    // Word only moves when rd is high, otherwise the last one holds
    always_ff @(posedge clk) begin
        if (rd) begin
            out <= mem[addr];
        end
    end

endmodule

//--- otter_mem_pkg.sv
package otter_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Access size
    ////////////////////////////////////////////////////////////////////////////

    // Encoding follows funct3[1:0] of RISC-V loads and stores
    // Code 2'b11 has no name and is rejected by every target
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } size_e;

    ////////////////////////////////////////////////////////////////////////////
    // Core side request and response
    ////////////////////////////////////////////////////////////////////////////

    // Store data sits in the low bits, as it leaves the register file
    typedef struct packed {
        logic [31:0] addr;
        size_e       size;
        logic        lu;
        logic        rd;
        logic        wr;
        logic [31:0] wdata;
    } mem_req_t;

    // Read data already shifted down and extended
    typedef struct packed {
        logic [31:0] rdata;
        logic        error;
    } mem_rsp_t;

    // Raw answer of one target, word as stored
    typedef struct packed {
        logic        hit;
        logic        error;
        logic [31:0] rdata;
    } tgt_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // MMIO register map, offsets inside the 256 byte window
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] MMIO_GPIO_OFS    = 8'h00;
    localparam logic [7:0] MMIO_SCRATCH_OFS = 8'h04;
    localparam logic [7:0] MMIO_COUNT_OFS   = 8'h08;

endpackage
